//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mc_sched
RTL_TOP   ?= mc_sched_top
FILELIST  ?= mc_sched.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- arb_row_col/arb_row_col.sv
`timescale 1ns/1ps

module arb_row_col (
  input  logic               clk,
  input  logic               rst_n,
  bank_arb_if.arb            banks,
  input  logic               ref_req,
  output logic               ref_ack,
  input  logic               room,
  output logic               wr_en,
  output mc_pkg::slot_pair_t wr_pair
);

  localparam int N = mc_pkg::N_BANK;

  logic [N-1:0]              row_request;
  logic [N-1:0]              col_request;
  logic [N-1:0]              grant_row_r;
  logic [N-1:0]              grant_col_r;
  logic                      granted_row_r;
  logic                      granted_col_r;
  logic                      sent_row;
  logic                      sent_col;
  logic                      ref_pend;
  logic                      ref_clear;
  logic                      ref_fire;
  logic                      ref_done_r;
  logic                      ref_ack_r;
  logic [mc_pkg::BANK_W-1:0] row_bank;
  logic [mc_pkg::BANK_W-1:0] col_bank;

  assign ref_pend = ref_req && !ref_done_r;

  // The bank being sent still requests this cycle, keep it out of the next grant
  assign row_request = banks.rts_row & ~(grant_row_r & {N{sent_row}}) & {N{~ref_pend}};
  // Columns of already opened rows keep flowing during refresh
  assign col_request = banks.rts_col & ~(grant_col_r & {N{sent_col}});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      granted_row_r <= 1'b0;
      granted_col_r <= 1'b0;
    end else begin
      granted_row_r <= |row_request;
      granted_col_r <= |col_request;
    end
  end

  assign sent_row = granted_row_r && room && !ref_pend;
  assign sent_col = granted_col_r && room;

  round_robin_arb #(.WIDTH(N)) row_arb0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (row_request),
    .upd_last_master (sent_row),
    .current_master  (grant_row_r),
    .grant_ns        (),
    .grant_r         (grant_row_r)
  );

  round_robin_arb #(.WIDTH(N)) col_arb0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (col_request),
    .upd_last_master (sent_col),
    .current_master  (grant_col_r),
    .grant_ns        (),
    .grant_r         (grant_col_r)
  );

  assign banks.grant_row = grant_row_r;
  assign banks.grant_col = grant_col_r;
  assign banks.sent_row  = sent_row;
  assign banks.sent_col  = sent_col;

  // No open row anywhere, pending row requests wait behind the refresh
  assign ref_clear = &(banks.idle | banks.rts_row);
  assign ref_fire  = ref_pend && ref_clear && room;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ref_done_r <= 1'b0;
      ref_ack_r  <= 1'b0;
    end else begin
      ref_done_r <= ref_req && (ref_done_r || ref_fire);  // Held until ref_req drops
      ref_ack_r  <= ref_fire;
    end
  end

  assign ref_ack = ref_ack_r;

  always_comb begin
    row_bank = '0;
    col_bank = '0;
    for (int i = 0; i < N; i++) begin
      if (grant_row_r[i]) row_bank = mc_pkg::BANK_W'(i);
      if (grant_col_r[i]) col_bank = mc_pkg::BANK_W'(i);
    end
  end

  always_comb begin
    wr_pair.slot0 = mc_pkg::NOP_SLOT;
    wr_pair.slot1 = mc_pkg::NOP_SLOT;
    if (ref_fire) begin
      wr_pair.slot0.cmd = mc_pkg::CMD_REF;
    end else if (sent_row) begin
      wr_pair.slot0.cmd  = mc_pkg::CMD_ACT;
      wr_pair.slot0.bank = row_bank;
      wr_pair.slot0.addr = mc_pkg::ADDR_W'(banks.row_addr[row_bank]);
    end
    if (sent_col) begin
      wr_pair.slot1.cmd  = banks.col_wr[col_bank] ? mc_pkg::CMD_WR : mc_pkg::CMD_RD;
      wr_pair.slot1.bank = col_bank;
      wr_pair.slot1.addr = mc_pkg::ADDR_W'(banks.col_addr[col_bank]);
    end
  end

  assign wr_en = sent_row || sent_col || ref_fire;

endmodule

//--- common/bank_arb_if.sv
`timescale 1ns/1ps

interface bank_arb_if;

  // Bank side
  logic [mc_pkg::N_BANK-1:0] rts_row;
  logic [mc_pkg::N_BANK-1:0] rts_col;
  logic [mc_pkg::ROW_W-1:0]  row_addr [mc_pkg::N_BANK];
  logic [mc_pkg::COL_W-1:0]  col_addr [mc_pkg::N_BANK];
  logic [mc_pkg::N_BANK-1:0] col_wr;
  logic [mc_pkg::N_BANK-1:0] idle;

  // Arbiter side
  logic [mc_pkg::N_BANK-1:0] grant_row;
  logic [mc_pkg::N_BANK-1:0] grant_col;
  logic                      sent_row;
  logic                      sent_col;

  modport bank (
    output rts_row, rts_col, row_addr, col_addr, col_wr, idle,
    input  grant_row, grant_col, sent_row, sent_col
  );

  modport arb (
    input  rts_row, rts_col, row_addr, col_addr, col_wr, idle,
    output grant_row, grant_col, sent_row, sent_col
  );

endinterface

//--- common/mc_pkg.sv
package mc_pkg;

  localparam int N_BANK     = 4;
  localparam int BANK_W     = 2;
  localparam int ROW_W      = 14;
  localparam int COL_W      = 10;
  localparam int ADDR_W     = (ROW_W > COL_W) ? ROW_W : COL_W;

  localparam int N_RCD      = 3;  // ACT sent to column request
  localparam int N_RP       = 4;  // Recovery after auto-precharge
  localparam int CNT_W      = 3;  // Wide enough for N_RCD and N_RP

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  typedef enum logic [2:0] {
    CMD_NOP = 3'd0,
    CMD_ACT = 3'd1,
    CMD_RD  = 3'd2,
    CMD_WR  = 3'd3,
    CMD_REF = 3'd4
  } cmd_e;

  typedef struct packed {
    cmd_e              cmd;
    logic [BANK_W-1:0] bank;
    logic [ADDR_W-1:0] addr;
  } slot_t;

  // Slot 0 carries row and refresh, slot 1 carries column commands
  typedef struct packed {
    slot_t slot0;
    slot_t slot1;
  } slot_pair_t;

  localparam slot_t NOP_SLOT = '{cmd: CMD_NOP, bank: '0, addr: '0};

endpackage

//--- mc_sched.f
common/mc_pkg.sv
common/bank_arb_if.sv
src/round_robin_arb.sv
arb_row_col/arb_row_col.sv
src/bank_mach.sv
src/cmd_fifo.sv
src/cmd_issue.sv
src/mc_sched_top.sv
testbench/mc_sched_properties.sv
testbench/tb_mc_sched.sv

//--- src/bank_mach.sv
`timescale 1ns/1ps

module bank_mach (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [mc_pkg::BANK_W-1:0] bank_id,
  input  logic                      load,
  input  logic [mc_pkg::ROW_W-1:0]  row,
  input  logic [mc_pkg::COL_W-1:0]  col,
  input  logic                      wr,
  bank_arb_if.bank                  arb
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ROW,
    S_RCD,
    S_COL
  } state_e;

  state_e                   state;
  logic [mc_pkg::CNT_W-1:0] cnt;  // tRCD in S_RCD, recovery in S_IDLE
  logic [mc_pkg::ROW_W-1:0] row_q;
  logic [mc_pkg::COL_W-1:0] col_q;
  logic                     wr_q;
  logic                     idle;
  logic                     row_sent;
  logic                     col_sent;

  assign idle     = (state == S_IDLE) && (cnt == '0);
  assign row_sent = arb.grant_row[bank_id] && arb.sent_row;
  assign col_sent = arb.grant_col[bank_id] && arb.sent_col;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else if (load) begin
            state <= S_ROW;
          end
        end
        S_ROW: begin
          if (row_sent) begin
            state <= S_RCD;
            cnt   <= mc_pkg::CNT_W'(mc_pkg::N_RCD - 1);
          end
        end
        S_RCD: begin
          if (cnt == '0) begin
            state <= S_COL;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        S_COL: begin
          if (col_sent) begin
            state <= S_IDLE;
            cnt   <= mc_pkg::CNT_W'(mc_pkg::N_RP);  // Auto-precharge recovery
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load && idle) begin
      row_q <= row;
      col_q <= col;
      wr_q  <= wr;
    end
  end

  // Each bank owns one entry of the shared vectors
  always @* begin
    arb.rts_row[bank_id]  = (state == S_ROW);
    arb.rts_col[bank_id]  = (state == S_COL);
    arb.idle[bank_id]     = idle;
    arb.col_wr[bank_id]   = wr_q;
    arb.row_addr[bank_id] = row_q;
    arb.col_addr[bank_id] = col_q;
  end

endmodule

//--- src/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr_en,
  input  mc_pkg::slot_pair_t wr_pair,
  input  logic               rd_en,
  output mc_pkg::slot_pair_t rd_pair,
  output logic               empty,
  output logic               room
);

  localparam int AW = mc_pkg::FIFO_AW;

  mc_pkg::slot_pair_t mem [mc_pkg::FIFO_DEPTH];
  logic [AW-1:0]      wr_ptr;
  logic [AW-1:0]      rd_ptr;
  logic [AW:0]        count;
  logic               do_wr;
  logic               do_rd;

  assign do_wr = wr_en && (count != (AW + 1)'(mc_pkg::FIFO_DEPTH));
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_pair;
  end

  // Fall-through read
  assign rd_pair = mem[rd_ptr];
  assign empty   = (count == '0);
  // Two free entries, one for a pair already granted
  assign room    = (count <= (AW + 1)'(mc_pkg::FIFO_DEPTH - 2));

endmodule

//--- src/cmd_issue.sv
`timescale 1ns/1ps

module cmd_issue (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      phy_ready,
  input  logic                      empty,
  input  mc_pkg::slot_pair_t        rd_pair,
  output logic                      rd_en,
  output logic                      cs_en0,
  output mc_pkg::cmd_e              cmd0,
  output logic [mc_pkg::BANK_W-1:0] bank0,
  output logic [mc_pkg::ADDR_W-1:0] addr0,
  output logic                      cs_en1,
  output mc_pkg::cmd_e              cmd1,
  output logic [mc_pkg::BANK_W-1:0] bank1,
  output logic [mc_pkg::ADDR_W-1:0] addr1
);

  assign rd_en = phy_ready && !empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cs_en0 <= 1'b0;
      cs_en1 <= 1'b0;
      cmd0   <= mc_pkg::CMD_NOP;
      cmd1   <= mc_pkg::CMD_NOP;
    end else if (rd_en) begin
      cs_en0 <= (rd_pair.slot0.cmd != mc_pkg::CMD_NOP);
      cs_en1 <= (rd_pair.slot1.cmd != mc_pkg::CMD_NOP);
      cmd0   <= rd_pair.slot0.cmd;
      cmd1   <= rd_pair.slot1.cmd;
    end else begin
      // Nothing popped, both slots idle
      cs_en0 <= 1'b0;
      cs_en1 <= 1'b0;
      cmd0   <= mc_pkg::CMD_NOP;
      cmd1   <= mc_pkg::CMD_NOP;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      bank0 <= rd_pair.slot0.bank;
      addr0 <= rd_pair.slot0.addr;
      bank1 <= rd_pair.slot1.bank;
      addr1 <= rd_pair.slot1.addr;
    end
  end

endmodule

//--- src/mc_sched_top.sv
`timescale 1ns/1ps

module mc_sched_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_valid,
  input  logic [mc_pkg::BANK_W-1:0] req_bank,
  input  logic [mc_pkg::ROW_W-1:0]  req_row,
  input  logic [mc_pkg::COL_W-1:0]  req_col,
  input  logic                      req_wr,
  output logic                      req_ready,
  input  logic                      ref_req,
  output logic                      ref_ack,
  input  logic                      phy_ready,
  output logic                      cs_en0,
  output mc_pkg::cmd_e              cmd0,
  output logic [mc_pkg::BANK_W-1:0] bank0,
  output logic [mc_pkg::ADDR_W-1:0] addr0,
  output logic                      cs_en1,
  output mc_pkg::cmd_e              cmd1,
  output logic [mc_pkg::BANK_W-1:0] bank1,
  output logic [mc_pkg::ADDR_W-1:0] addr1
);

  bank_arb_if bank_if ();

  logic [mc_pkg::N_BANK-1:0] load;
  logic                      wr_en;
  logic                      room;
  logic                      rd_en;
  logic                      empty;
  mc_pkg::slot_pair_t        wr_pair;
  mc_pkg::slot_pair_t        rd_pair;

  assign req_ready = bank_if.idle[req_bank];

  for (genvar g = 0; g < mc_pkg::N_BANK; g++) begin : g_bank
    assign load[g] = req_valid && req_ready && (req_bank == mc_pkg::BANK_W'(g));

    bank_mach u_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .bank_id (mc_pkg::BANK_W'(g)),
      .load    (load[g]),
      .row     (req_row),
      .col     (req_col),
      .wr      (req_wr),
      .arb     (bank_if.bank)
    );
  end

  arb_row_col arb0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .banks   (bank_if.arb),
    .ref_req (ref_req),
    .ref_ack (ref_ack),
    .room    (room),
    .wr_en   (wr_en),
    .wr_pair (wr_pair)
  );

  cmd_fifo fifo0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_pair (wr_pair),
    .rd_en   (rd_en),
    .rd_pair (rd_pair),
    .empty   (empty),
    .room    (room)
  );

  cmd_issue issue0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .phy_ready (phy_ready),
    .empty     (empty),
    .rd_pair   (rd_pair),
    .rd_en     (rd_en),
    .cs_en0    (cs_en0),
    .cmd0      (cmd0),
    .bank0     (bank0),
    .addr0     (addr0),
    .cs_en1    (cs_en1),
    .cmd1      (cmd1),
    .bank1     (bank1),
    .addr1     (addr1)
  );

endmodule

//--- src/round_robin_arb.sv
`timescale 1ns/1ps

module round_robin_arb #(
  parameter int WIDTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] req,
  input  logic             upd_last_master,
  input  logic [WIDTH-1:0] current_master,
  output logic [WIDTH-1:0] grant_ns,
  output logic [WIDTH-1:0] grant_r
);

  logic [WIDTH-1:0] last_master_r;
  logic [WIDTH-1:0] last_master_ns;

  // A grant that was never sent keeps the old last master
  assign last_master_ns = upd_last_master ? current_master : last_master_r;

  always_comb begin : search
    int   lm_idx;
    int   idx;
    logic found;
    lm_idx = WIDTH - 1;
    for (int i = 0; i < WIDTH; i++) begin
      if (last_master_ns[i]) lm_idx = i;
    end
    grant_ns = '0;
    found = 1'b0;
    // Start one past the last master, wrap around
    for (int k = 1; k <= WIDTH; k++) begin
      idx = (lm_idx + k) % WIDTH;
      if (!found && req[idx]) begin
        grant_ns[idx] = 1'b1;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_r       <= '0;
      last_master_r <= WIDTH'(1) << (WIDTH - 1);  // Bit 0 wins first
    end else begin
      grant_r       <= grant_ns;
      last_master_r <= last_master_ns;
    end
  end

endmodule

//--- testbench/mc_sched_properties.sv
`timescale 1ns/1ps

module mc_sched_properties (
  input logic                      clk,
  input logic                      rst_n,
  input logic [mc_pkg::N_BANK-1:0] grant_row,
  input logic [mc_pkg::N_BANK-1:0] grant_col,
  input logic                      wr_en,
  input logic                      room,
  input logic                      ref_req,
  input mc_pkg::cmd_e              slot0_cmd
);

  int   fail_count = 0;  // Read by the testbench at the end of the run
  logic ref_written_r;   // REF already queued for this ref_req

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ref_written_r <= 1'b0;
    end else begin
      ref_written_r <= ref_req &&
                       (ref_written_r || (wr_en && slot0_cmd == mc_pkg::CMD_REF));
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant_row) && $onehot0(grant_col))
  else begin
    fail_count++;
    $error("grant not one-hot, row %b col %b", grant_row, grant_col);
  end

  a_wr_needs_room: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> room)
  else begin
    fail_count++;
    $error("FIFO write without room");
  end

  // Row commands stay blocked until the REF has gone in
  a_no_act_in_ref: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en && ref_req && !ref_written_r |-> slot0_cmd != mc_pkg::CMD_ACT)
  else begin
    fail_count++;
    $error("ACT written while refresh pending");
  end

endmodule

bind arb_row_col mc_sched_properties props0 (
  .clk       (clk),
  .rst_n     (rst_n),
  .grant_row (grant_row_r),
  .grant_col (grant_col_r),
  .wr_en     (wr_en),
  .room      (room),
  .ref_req   (ref_req),
  .slot0_cmd (wr_pair.slot0.cmd)
);

//--- testbench/tb_mc_sched.sv
`timescale 1ns/1ps

module tb_mc_sched;

  localparam int CLK_PERIOD = 40;
  localparam int N_TESTS    = 6;
  localparam int WAIT_MAX   = 200;  // Cycles allowed for any single wait

  logic                      clk;
  logic                      rst_n;
  logic                      req_valid;
  logic [mc_pkg::BANK_W-1:0] req_bank;
  logic [mc_pkg::ROW_W-1:0]  req_row;
  logic [mc_pkg::COL_W-1:0]  req_col;
  logic                      req_wr;
  logic                      req_ready;
  logic                      ref_req;
  logic                      ref_ack;
  logic                      phy_ready;
  logic                      cs_en0;
  mc_pkg::cmd_e              cmd0;
  logic [mc_pkg::BANK_W-1:0] bank0;
  logic [mc_pkg::ADDR_W-1:0] addr0;
  logic                      cs_en1;
  mc_pkg::cmd_e              cmd1;
  logic [mc_pkg::BANK_W-1:0] bank1;
  logic [mc_pkg::ADDR_W-1:0] addr1;

  // Every issued command, in output order
  mc_pkg::cmd_e              log_cmd [$];
  logic [mc_pkg::BANK_W-1:0] log_bank [$];
  logic [mc_pkg::ADDR_W-1:0] log_addr [$];
  int                        log_slot [$];
  int                        log_cyc [$];

  int     cyc = 0;
  int     ref_acks = 0;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  integer seed = 49078;

  mc_sched_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_bank  (req_bank),
    .req_row   (req_row),
    .req_col   (req_col),
    .req_wr    (req_wr),
    .req_ready (req_ready),
    .ref_req   (ref_req),
    .ref_ack   (ref_ack),
    .phy_ready (phy_ready),
    .cs_en0    (cs_en0),
    .cmd0      (cmd0),
    .bank0     (bank0),
    .addr0     (addr0),
    .cs_en1    (cs_en1),
    .cmd1      (cmd1),
    .bank1     (bank1),
    .addr1     (addr1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (cs_en0) begin
        log_cmd.push_back(cmd0);
        log_bank.push_back(bank0);
        log_addr.push_back(addr0);
        log_slot.push_back(0);
        log_cyc.push_back(cyc);
      end
      if (cs_en1) begin
        log_cmd.push_back(cmd1);
        log_bank.push_back(bank1);
        log_addr.push_back(addr1);
        log_slot.push_back(1);
        log_cyc.push_back(cyc);
      end
      if (ref_ack) ref_acks++;
    end
  end

  initial begin
    #(N_TESTS * 400 * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run stopped", N_TESTS * 400);
    $display("TEST FAIL");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic pick_addr(output logic [mc_pkg::ROW_W-1:0] row,
                           output logic [mc_pkg::COL_W-1:0] col);
    logic [31:0] r;
    r = $random(seed);
    row = r[mc_pkg::ROW_W-1:0];
    r = $random(seed);
    col = r[mc_pkg::COL_W-1:0];
  endtask

  // Holds the request until the bank takes it, acc_cyc is the accepting cycle
  task automatic send_req(input logic [mc_pkg::BANK_W-1:0] bank,
                          input logic [mc_pkg::ROW_W-1:0] row,
                          input logic [mc_pkg::COL_W-1:0] col,
                          input logic wr, output int acc_cyc);
    int t;
    req_valid = 1'b1;
    req_bank  = bank;
    req_row   = row;
    req_col   = col;
    req_wr    = wr;
    t = 0;
    #1;
    while (!req_ready && t < WAIT_MAX) begin
      @(posedge clk);
      #3;
      t++;
    end
    if (!req_ready) begin
      $display("Request to bank %0d was never accepted", bank);
      errors++;
    end
    acc_cyc = cyc;
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic wait_bank_idle(input logic [mc_pkg::BANK_W-1:0] bank, output bit ok);
    int t;
    req_bank = bank;
    t = 0;
    #1;
    while (!req_ready && t < WAIT_MAX) begin
      @(posedge clk);
      #3;
      t++;
    end
    ok = req_ready;
    next_cycle();
  endtask

  task automatic wait_log(input int n);
    int t;
    t = 0;
    while (log_cmd.size() < n && t < WAIT_MAX) begin
      next_cycle();
      t++;
    end
    if (log_cmd.size() < n) begin
      $display("Only %0d of %0d expected commands were issued", log_cmd.size(), n);
      errors++;
    end
  endtask

  function automatic int find_cmd(input mc_pkg::cmd_e cmd,
                                  input logic [mc_pkg::BANK_W-1:0] bank);
    for (int i = 0; i < log_cmd.size(); i++) begin
      if (log_cmd[i] == cmd && log_bank[i] == bank) return i;
    end
    return -1;
  endfunction

  function automatic int count_cmd(input mc_pkg::cmd_e cmd,
                                   input logic [mc_pkg::BANK_W-1:0] bank);
    int n;
    n = 0;
    for (int i = 0; i < log_cmd.size(); i++) begin
      if (log_cmd[i] == cmd && log_bank[i] == bank) n++;
    end
    return n;
  endfunction

  function automatic mc_pkg::cmd_e col_cmd(input logic wr);
    return wr ? mc_pkg::CMD_WR : mc_pkg::CMD_RD;
  endfunction

  task automatic check_entry(input int idx, input mc_pkg::cmd_e cmd,
                             input logic [mc_pkg::BANK_W-1:0] bank,
                             input logic [mc_pkg::ADDR_W-1:0] addr);
    int exp_slot;
    exp_slot = (cmd == mc_pkg::CMD_RD || cmd == mc_pkg::CMD_WR) ? 1 : 0;  // Column on slot 1
    if (idx < 0 || idx >= log_cmd.size()) begin
      $display("Expected command 0x%h for bank %0d was not issued", cmd, bank);
      errors++;
    end else begin
      if (log_cmd[idx] != cmd) begin
        $display("FAIL cmd%0d expected 0x%h got 0x%h", log_slot[idx], cmd, log_cmd[idx]);
        errors++;
      end
      if (log_slot[idx] != exp_slot) begin
        $display("Command 0x%h went out on slot %0d", cmd, log_slot[idx]);
        errors++;
      end
      if (log_bank[idx] != bank) begin
        $display("FAIL bank%0d expected 0x%h got 0x%h", log_slot[idx], bank, log_bank[idx]);
        errors++;
      end
      if (log_addr[idx] != addr) begin
        $display("FAIL addr%0d expected 0x%h got 0x%h", log_slot[idx], addr, log_addr[idx]);
        errors++;
      end
    end
  endtask

  // Lets every bank drain, then checks nothing extra went out
  task automatic end_test(input string name, input int err0, input int n_exp);
    bit ok;
    for (int b = 0; b < mc_pkg::N_BANK; b++) begin
      wait_bank_idle(mc_pkg::BANK_W'(b), ok);
      if (!ok) begin
        $display("Bank %0d never returned to idle", b);
        errors++;
      end
    end
    if (log_cmd.size() != n_exp) begin
      $display("FAIL command_count expected 0x%h got 0x%h", n_exp, log_cmd.size());
      errors++;
    end
    tests_run++;
    if (errors != err0) tests_failed++;
    $display("%s: %s", name, (errors == err0) ? "ok" : "failed");
    log_cmd.delete();
    log_bank.delete();
    log_addr.delete();
    log_slot.delete();
    log_cyc.delete();
  endtask

  task automatic test_single_read();
    int                       err0;
    int                       acc;
    logic [mc_pkg::ROW_W-1:0] row;
    logic [mc_pkg::COL_W-1:0] col;
    err0 = errors;
    pick_addr(row, col);
    send_req(2'd1, row, col, 1'b0, acc);
    wait_log(2);
    check_entry(0, mc_pkg::CMD_ACT, 2'd1, row);
    check_entry(1, mc_pkg::CMD_RD, 2'd1, mc_pkg::ADDR_W'(col));
    if (log_cyc.size() > 0 && log_cyc[0] - acc != 4) begin
      $display("FAIL act_latency expected 0x%h got 0x%h", 4, log_cyc[0] - acc);
      errors++;
    end
    end_test("single read", err0, 2);
  endtask

  task automatic test_single_write();
    int                       err0;
    int                       acc;
    logic [mc_pkg::ROW_W-1:0] row;
    logic [mc_pkg::COL_W-1:0] col;
    err0 = errors;
    pick_addr(row, col);
    send_req(2'd3, row, col, 1'b1, acc);
    wait_log(2);
    check_entry(0, mc_pkg::CMD_ACT, 2'd3, row);
    check_entry(1, mc_pkg::CMD_WR, 2'd3, mc_pkg::ADDR_W'(col));
    if (log_cyc.size() > 1 && log_cyc[1] - log_cyc[0] < mc_pkg::N_RCD) begin
      $display("FAIL act_to_wr expected >= 0x%h got 0x%h", mc_pkg::N_RCD,
               log_cyc[1] - log_cyc[0]);
      errors++;
    end
    end_test("single write", err0, 2);
  endtask

  task automatic test_all_banks();
    int                       err0;
    int                       acc;
    int                       a_idx;
    int                       c_idx;
    int                       last_act;
    int                       first_col;
    logic [mc_pkg::ROW_W-1:0] rows [mc_pkg::N_BANK];
    logic [mc_pkg::COL_W-1:0] cols [mc_pkg::N_BANK];
    err0 = errors;
    last_act = 0;
    first_col = 1 << 30;
    for (int b = 0; b < mc_pkg::N_BANK; b++) begin
      pick_addr(rows[b], cols[b]);
      send_req(mc_pkg::BANK_W'(b), rows[b], cols[b], b[0], acc);
    end
    wait_log(2 * mc_pkg::N_BANK);
    for (int b = 0; b < mc_pkg::N_BANK; b++) begin
      a_idx = find_cmd(mc_pkg::CMD_ACT, mc_pkg::BANK_W'(b));
      c_idx = find_cmd(col_cmd(b[0]), mc_pkg::BANK_W'(b));
      check_entry(a_idx, mc_pkg::CMD_ACT, mc_pkg::BANK_W'(b), rows[b]);
      check_entry(c_idx, col_cmd(b[0]), mc_pkg::BANK_W'(b), mc_pkg::ADDR_W'(cols[b]));
      if (count_cmd(mc_pkg::CMD_ACT, mc_pkg::BANK_W'(b)) != 1 ||
          count_cmd(col_cmd(b[0]), mc_pkg::BANK_W'(b)) != 1) begin
        $display("Bank %0d did not get exactly one ACT and one column command", b);
        errors++;
      end
      if (a_idx >= 0 && c_idx >= 0) begin
        if (c_idx < a_idx) begin
          $display("Bank %0d column command came before its ACT", b);
          errors++;
        end
        if (log_cyc[a_idx] > last_act) last_act = log_cyc[a_idx];
        if (log_cyc[c_idx] < first_col) first_col = log_cyc[c_idx];
      end
    end
    if (first_col <= last_act) begin
      $display("A column command went out before every bank had its ACT");
      errors++;
    end
    end_test("four banks", err0, 2 * mc_pkg::N_BANK);
  endtask

  task automatic test_back_pressure();
    int                       err0;
    int                       acc;
    int                       h0;
    logic [mc_pkg::ROW_W-1:0] rows [mc_pkg::N_BANK];
    logic [mc_pkg::COL_W-1:0] cols [mc_pkg::N_BANK];
    err0 = errors;
    phy_ready = 1'b0;
    h0 = cyc;
    for (int b = 0; b < mc_pkg::N_BANK; b++) begin
      pick_addr(rows[b], cols[b]);
      send_req(mc_pkg::BANK_W'(b), rows[b], cols[b], ~b[0], acc);
    end
    while (cyc - h0 < 30) next_cycle();
    if (log_cmd.size() != 0) begin
      $display("A chip select went high while phy_ready was low");
      errors++;
    end
    phy_ready = 1'b1;
    wait_log(2 * mc_pkg::N_BANK);
    // All ACTs were queued before the first column
    for (int b = 0; b < mc_pkg::N_BANK; b++) begin
      check_entry(b, mc_pkg::CMD_ACT, mc_pkg::BANK_W'(b), rows[b]);
      check_entry(b + mc_pkg::N_BANK, col_cmd(~b[0]), mc_pkg::BANK_W'(b),
                  mc_pkg::ADDR_W'(cols[b]));
    end
    end_test("back-pressure", err0, 2 * mc_pkg::N_BANK);
  endtask

  task automatic test_refresh();
    int                       err0;
    int                       acc;
    int                       t;
    int                       ref_cyc;
    int                       ref_idx;
    int                       c_idx;
    logic [mc_pkg::ROW_W-1:0] rows [mc_pkg::N_BANK];
    logic [mc_pkg::COL_W-1:0] cols [mc_pkg::N_BANK];
    err0 = errors;
    ref_acks = 0;
    for (int b = 0; b < 3; b++) begin
      pick_addr(rows[b], cols[b]);
      send_req(mc_pkg::BANK_W'(b), rows[b], cols[b], 1'b0, acc);
    end
    wait_log(3);
    ref_req = 1'b1;
    ref_cyc = cyc;
    pick_addr(rows[3], cols[3]);
    send_req(2'd3, rows[3], cols[3], 1'b1, acc);  // Row must wait behind the refresh
    t = 0;
    while (ref_acks == 0 && t < WAIT_MAX) begin
      next_cycle();
      t++;
    end
    if (ref_acks == 0) begin
      $display("ref_ack never pulsed");
      errors++;
    end
    next_cycle();
    ref_req = 1'b0;
    wait_log(9);
    ref_idx = find_cmd(mc_pkg::CMD_REF, 2'd0);
    check_entry(ref_idx, mc_pkg::CMD_REF, 2'd0, '0);
    if (ref_idx >= 0) begin
      for (int b = 0; b < 3; b++) begin
        c_idx = find_cmd(mc_pkg::CMD_RD, mc_pkg::BANK_W'(b));
        if (c_idx < 0 || c_idx > ref_idx) begin
          $display("Column command of bank %0d did not precede the REF", b);
          errors++;
        end
      end
      for (int i = 0; i < ref_idx; i++) begin
        if (log_cmd[i] == mc_pkg::CMD_ACT && log_cyc[i] >= ref_cyc) begin
          $display("ACT for bank %0d issued while refresh was pending", log_bank[i]);
          errors++;
        end
      end
    end
    check_entry(find_cmd(mc_pkg::CMD_ACT, 2'd3), mc_pkg::CMD_ACT, 2'd3, rows[3]);
    check_entry(find_cmd(mc_pkg::CMD_WR, 2'd3), mc_pkg::CMD_WR, 2'd3, mc_pkg::ADDR_W'(cols[3]));
    if (ref_acks != 1) begin
      $display("FAIL ref_ack expected 0x%h got 0x%h", 1, ref_acks);
      errors++;
    end
    end_test("refresh", err0, 9);
  endtask

  task automatic test_idle_return();
    int                       err0;
    int                       acc;
    bit                       ok;
    logic [mc_pkg::ROW_W-1:0] row;
    logic [mc_pkg::COL_W-1:0] col;
    logic [mc_pkg::ROW_W-1:0] row2;
    logic [mc_pkg::COL_W-1:0] col2;
    err0 = errors;
    pick_addr(row, col);
    send_req(2'd2, row, col, 1'b0, acc);
    if (req_ready !== 1'b0) begin
      $display("FAIL req_ready expected 0x%h got 0x%h", 1'b0, req_ready);
      errors++;
    end
    wait_log(2);
    wait_bank_idle(2'd2, ok);
    if (!ok) begin
      $display("req_ready for bank 2 never came back after recovery");
      errors++;
    end
    pick_addr(row2, col2);
    send_req(2'd2, row2, col2, 1'b1, acc);
    wait_log(4);
    check_entry(2, mc_pkg::CMD_ACT, 2'd2, row2);
    check_entry(3, mc_pkg::CMD_WR, 2'd2, mc_pkg::ADDR_W'(col2));
    end_test("idle after recovery", err0, 4);
  endtask

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_bank  = '0;
    req_row   = '0;
    req_col   = '0;
    req_wr    = 1'b0;
    ref_req   = 1'b0;
    phy_ready = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    if (req_ready !== 1'b1 || cs_en0 !== 1'b0 || cs_en1 !== 1'b0 || ref_ack !== 1'b0) begin
      $display("Outputs not at their reset values");
      errors++;
    end
    test_single_read();
    test_single_write();
    test_all_banks();
    test_back_pressure();
    test_refresh();
    test_idle_return();
    $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, UUT.arb0.props0.fail_count);
    if (errors == 0 && UUT.arb0.props0.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
